//--- rtl/lsPkg.sv
package lsPkg;

    parameter int DataWidth = 32;
    parameter int TagWidth  = 4;
    parameter int NameWidth = 5;

    typedef enum logic [2:0] {
        opLb,
        opLh,
        opLw,
        opLbu,
        opLhu,
        opSb,
        opSh,
        opSw
    } lsOp;

    // access size in bytes minus one, shared by loads and stores
    typedef logic [1:0] lenCode;

    parameter lenCode LenByte = 2'd0;
    parameter lenCode LenHalf = 2'd1;
    parameter lenCode LenWord = 2'd3;

    typedef struct packed {
        lsOp                  op;
        logic [DataWidth-1:0] base;
        logic [DataWidth-1:0] offset;
        logic [DataWidth-1:0] storeData;
        logic [TagWidth-1:0]  tag;
        logic [NameWidth-1:0] name;
    } lsReq;

    typedef struct packed {
        logic                 en;
        logic                 write;
        logic [DataWidth-1:0] addr;
        lenCode               len;
        logic [DataWidth-1:0] data;
    } memReq;

    typedef struct packed {
        logic                 en;
        logic [DataWidth-1:0] data;
        logic [TagWidth-1:0]  tag;
        logic [NameWidth-1:0] name;
    } robWrite;

endpackage

//--- rtl/lsQueue.sv
module lsQueue #(
    parameter int QueueDepth = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        issueEn,
    input  lsPkg::lsReq issueReq,
    output logic        full,
    input  logic        busy,
    output logic        workEn,
    output lsPkg::lsReq workReq
);
    import lsPkg::*;

    localparam int PtrWidth   = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int CountWidth = $clog2(QueueDepth + 1);

    lsReq                  entries [QueueDepth];
    logic [PtrWidth-1:0]   rdPtr;
    logic [PtrWidth-1:0]   wrPtr;
    logic [CountWidth-1:0] count;
    logic                  empty;
    logic                  push;
    logic                  pop;
    lsReq                  headReq;

    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        return (ptr == PtrWidth'(QueueDepth - 1)) ? '0 : ptr + PtrWidth'(1);
    endfunction

    assign empty = (count == '0);
    assign full  = (count == CountWidth'(QueueDepth));
    assign push  = issueEn && !full;

    // an empty queue hands a fresh issue straight through to the unit
    assign headReq = empty ? issueReq : entries[rdPtr];

    // busy only rises a cycle after our strobe, so the strobe cycle itself counts as busy
    assign pop = (!empty || push) && !busy && !workEn;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdPtr  <= '0;
            wrPtr  <= '0;
            count  <= '0;
            workEn <= 1'b0;
        end else begin
            workEn <= pop;
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, pop})
                2'b10:   count <= count + CountWidth'(1);
                2'b01:   count <= count - CountWidth'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= issueReq;
        end
        if (pop) begin
            workReq <= headReq;
        end
    end

    noIssueWhenFull: assert property (@(posedge clk) disable iff (rst) issueEn |-> !full)
        else $error("issue strobe while the queue is full");

endmodule

//--- rtl/lsUnit.sv
module lsUnit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        workEn,
    input  lsPkg::lsReq                 workReq,
    output logic                        busy,
    output lsPkg::memReq                memOut,
    input  logic                        outEn,
    input  logic [lsPkg::DataWidth-1:0] loadData,
    output lsPkg::robWrite              result,
    output logic                        done
);
    import lsPkg::*;

    logic                 pending;
    logic                 memEn;
    logic                 resultEn;
    logic                 reqWrite;
    logic                 signExt;
    lenCode               reqLen;
    logic [DataWidth-1:0] reqAddr;
    logic [DataWidth-1:0] reqData;
    logic [TagWidth-1:0]  reqTag;
    logic [NameWidth-1:0] reqName;
    logic [DataWidth-1:0] resultData;
    lenCode               opLen;
    logic                 opWrite;
    logic                 opSigned;
    logic [DataWidth-1:0] extData;

    assign busy = pending;

    always_comb begin
        opLen    = LenWord;
        opWrite  = 1'b0;
        opSigned = 1'b1;
        case (workReq.op)
            opLb:  opLen = LenByte;
            opLh:  opLen = LenHalf;
            opLw:  opLen = LenWord;
            opLbu: begin
                opLen    = LenByte;
                opSigned = 1'b0;
            end
            opLhu: begin
                opLen    = LenHalf;
                opSigned = 1'b0;
            end
            opSb: begin
                opLen   = LenByte;
                opWrite = 1'b1;
            end
            opSh: begin
                opLen   = LenHalf;
                opWrite = 1'b1;
            end
            default: opWrite = 1'b1;
        endcase
    end

    // the memory returns the bytes right-aligned, only the upper fill differs
    always_comb begin
        case (reqLen)
            LenByte: extData = {{(DataWidth-8){signExt & loadData[7]}}, loadData[7:0]};
            LenHalf: extData = {{(DataWidth-16){signExt & loadData[15]}}, loadData[15:0]};
            default: extData = loadData;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending  <= 1'b0;
            memEn    <= 1'b0;
            resultEn <= 1'b0;
            done     <= 1'b0;
        end else begin
            memEn    <= workEn && !pending;
            resultEn <= pending && outEn && !reqWrite;
            done     <= pending && outEn;
            if (!pending && workEn) begin
                pending <= 1'b1;
            end else if (pending && outEn) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!pending && workEn) begin
            reqAddr  <= workReq.base + workReq.offset;
            reqWrite <= opWrite;
            reqLen   <= opLen;
            reqData  <= workReq.storeData;
            reqTag   <= workReq.tag;
            reqName  <= workReq.name;
            signExt  <= opSigned;
        end
        if (pending && outEn) begin
            resultData <= extData;
        end
    end

    // tag and name stay put until the next work strobe, which comes after done
    assign memOut = '{en: memEn, write: reqWrite, addr: reqAddr, len: reqLen, data: reqData};
    assign result = '{en: resultEn, data: resultData, tag: reqTag, name: reqName};

    alignedAccess: assert property (@(posedge clk) disable iff (rst)
        memEn |-> ((reqAddr[1:0] & reqLen) == 2'b00))
        else $error("misaligned access at address %h", reqAddr);

    noWorkWhileBusy: assert property (@(posedge clk) disable iff (rst) workEn |-> !busy)
        else $error("work strobe while the unit is busy");

    outEnOnlyPending: assert property (@(posedge clk) disable iff (rst) outEn |-> pending)
        else $error("memory completion without a pending request");

endmodule

//--- rtl/dataMemory.sv
module dataMemory #(
    parameter int MemLatency = 2,
    parameter int MemWords   = 256
) (
    input  logic                        clk,
    input  logic                        rst,
    input  lsPkg::memReq                req,
    output logic                        outEn,
    output logic [lsPkg::DataWidth-1:0] loadData
);
    import lsPkg::*;

    localparam int IndexWidth = (MemWords > 1) ? $clog2(MemWords) : 1;
    localparam int WaitWidth  = $clog2(MemLatency + 1);
    localparam int Lanes      = DataWidth / 8;

    logic [DataWidth-1:0]  words [MemWords];
    logic                  active;
    logic [WaitWidth-1:0]  remaining;
    logic                  heldWrite;
    logic [IndexWidth-1:0] heldIndex;
    logic [1:0]            heldOffset;
    lenCode                heldLen;
    logic [DataWidth-1:0]  heldData;
    logic [Lanes-1:0]      laneMask;
    logic [DataWidth-1:0]  laneData;
    logic [DataWidth-1:0]  wordOut;

    // the request finishes in the cycle where one wait cycle is left
    assign outEn = active && (remaining == WaitWidth'(1));

    always_comb begin
        case (heldLen)
            LenByte: laneMask = Lanes'(1);
            LenHalf: laneMask = Lanes'(3);
            default: laneMask = '1;
        endcase
        laneMask = laneMask << heldOffset;
    end

    // little-endian, so the low address bits pick the byte lane directly
    assign laneData = heldData << {heldOffset, 3'b000};
    assign wordOut  = words[heldIndex] >> {heldOffset, 3'b000};

    always_comb begin
        case (heldLen)
            LenByte: loadData = {{(DataWidth-8){1'b0}}, wordOut[7:0]};
            LenHalf: loadData = {{(DataWidth-16){1'b0}}, wordOut[15:0]};
            default: loadData = wordOut;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active    <= 1'b0;
            remaining <= '0;
            for (int i = 0; i < MemWords; i++) begin
                words[i] <= '0;
            end
        end else begin
            if (req.en) begin
                active    <= 1'b1;
                remaining <= WaitWidth'(MemLatency);
            end else if (active) begin
                remaining <= remaining - WaitWidth'(1);
                if (remaining == WaitWidth'(1)) begin
                    active <= 1'b0;
                end
            end
            if (outEn && heldWrite) begin
                for (int b = 0; b < Lanes; b++) begin
                    if (laneMask[b]) begin
                        words[heldIndex][8*b +: 8] <= laneData[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.en) begin
            heldWrite  <= req.write;
            heldIndex  <= req.addr[IndexWidth+1:2];
            heldOffset <= req.addr[1:0];
            heldLen    <= req.len;
            heldData   <= req.data;
        end
    end

    oneRequestAtATime: assert property (@(posedge clk) disable iff (rst) req.en |-> !active)
        else $error("new memory request while one is still in flight");

endmodule

//--- rtl/lsTop.sv
module lsTop #(
    parameter int QueueDepth = 4,
    parameter int MemLatency = 2,
    parameter int MemWords   = 256
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           issueEn,
    input  lsPkg::lsReq    issueReq,
    output logic           full,
    output lsPkg::robWrite result,
    output logic           done
);
    import lsPkg::*;

    logic                 workEn;
    lsReq                 workReq;
    logic                 busy;
    memReq                memBus;
    logic                 outEn;
    logic [DataWidth-1:0] loadData;

    lsQueue #(
        .QueueDepth(QueueDepth)
    ) queue0 (
        .clk     (clk),
        .rst     (rst),
        .issueEn (issueEn),
        .issueReq(issueReq),
        .full    (full),
        .busy    (busy),
        .workEn  (workEn),
        .workReq (workReq)
    );

    lsUnit unit0 (
        .clk     (clk),
        .rst     (rst),
        .workEn  (workEn),
        .workReq (workReq),
        .busy    (busy),
        .memOut  (memBus),
        .outEn   (outEn),
        .loadData(loadData),
        .result  (result),
        .done    (done)
    );

    dataMemory #(
        .MemLatency(MemLatency),
        .MemWords  (MemWords)
    ) mem0 (
        .clk     (clk),
        .rst     (rst),
        .req     (memBus),
        .outEn   (outEn),
        .loadData(loadData)
    );

endmodule

//--- bench/lsTb.sv
module lsTb;
    timeunit 1ns;
    timeprecision 1ps;

    import lsPkg::*;

    localparam int QueueDepth = 4;
    localparam int MemLatency = 2;
    localparam int MemWords   = 256;
    localparam int WaitLimit  = 200;

    logic    clk = 1'b0;
    logic    rst;
    logic    issueWant;
    logic    issueEn;
    lsReq    issueReq;
    logic    full;
    robWrite result;
    logic    done;

    int      cycle = 0;
    int      issuedCount;
    int      doneCount = 0;
    int      latencyChecks = 0;
    logic    sawFull = 1'b0;
    int      latencyIndex;
    int      latencyStart;
    robWrite expected[$];

    // dispatch holds its request back while the queue reports full
    assign issueEn = issueWant && !full;

    lsTop #(
        .QueueDepth(QueueDepth),
        .MemLatency(MemLatency),
        .MemWords  (MemWords)
    ) dut0 (
        .clk     (clk),
        .rst     (rst),
        .issueEn (issueEn),
        .issueReq(issueReq),
        .full    (full),
        .result  (result),
        .done    (done)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic abortRun();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            abortRun();
        end
    endtask

    task automatic checkRobWrite(input robWrite got, input robWrite exp);
        if (got !== exp) begin
            $display("mismatch result: got data %h tag %h name %h expected data %h tag %h name %h",
                     got.data, got.tag, got.name, exp.data, exp.tag, exp.name);
            abortRun();
        end
    endtask

    task automatic checkDoneCount(input int got, input int exp);
        if (got != exp) begin
            $display("mismatch done count: got %h expected %h", got, exp);
            abortRun();
        end
    endtask

    task automatic checkLatency(input int got, input int exp);
        if (got != exp) begin
            $display("mismatch done latency: got %h cycles expected %h cycles", got, exp);
            abortRun();
        end
    endtask

    // results are checked in the middle of the cycle, away from the clock edge
    always @(negedge clk) begin
        if (!rst) begin
            if (full) begin
                sawFull = 1'b1;
            end
            if (result.en) begin
                if (expected.size() == 0) begin
                    $display("reorder buffer write with tag %h but no load outstanding",
                             result.tag);
                    abortRun();
                end else begin
                    checkRobWrite(result, expected.pop_front());
                end
            end
            if (done) begin
                if (doneCount == latencyIndex) begin
                    checkLatency(cycle - latencyStart, MemLatency + 3);
                    latencyChecks = latencyChecks + 1;
                end
                doneCount = doneCount + 1;
            end
        end
    end

    task automatic sendOp(input lsReq req, input int gap, input logic [31:0] expData);
        int waited;
        repeat (gap) begin
            @(posedge clk);
            issueWant <= 1'b0;
        end
        @(posedge clk);
        // with every earlier operation done the pipeline is idle, so the latency is exact
        if (doneCount == issuedCount) begin
            latencyIndex = issuedCount;
        end
        issueWant <= 1'b1;
        issueReq  <= req;
        waited = 0;
        @(negedge clk);
        while (!issueEn) begin
            waited++;
            if (waited > WaitLimit) begin
                $display("timeout: the queue stayed full for %0d cycles", WaitLimit);
                abortRun();
            end
            @(negedge clk);
        end
        if (latencyIndex == issuedCount) begin
            latencyStart = cycle;
        end
        if (req.op inside {opLb, opLh, opLw, opLbu, opLhu}) begin
            expected.push_back('{en: 1'b1, data: expData, tag: req.tag, name: req.name});
        end
        issuedCount++;
    endtask

    initial begin
        int          fd;
        int          rc;
        int          waited;
        string       line;
        int          opNum;
        int          gap;
        logic [31:0] base;
        logic [31:0] offset;
        logic [31:0] storeData;
        logic [31:0] tagWord;
        logic [31:0] nameWord;
        logic [31:0] expData;
        lsReq        req;

        rst          = 1'b1;
        issueWant    = 1'b0;
        issueReq     = '0;
        issuedCount  = 0;
        latencyIndex = -1;
        latencyStart = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        repeat (6) begin
            @(negedge clk);
            checkFlag("result.en", result.en, 1'b0);
            checkFlag("done", done, 1'b0);
            checkFlag("full", full, 1'b0);
        end

        fd = $fopen("bench/lsStimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file bench/lsStimulus.txt");
            abortRun();
        end
        rc = $fgets(line, fd);
        while (rc != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                rc = $sscanf(line, "%d %h %h %h %h %h %d %h", opNum, base, offset,
                             storeData, tagWord, nameWord, gap, expData);
                if (rc != 8) begin
                    $display("malformed stimulus line: %s", line);
                    abortRun();
                end
                req.op        = lsOp'(opNum[2:0]);
                req.base      = base;
                req.offset    = offset;
                req.storeData = storeData;
                req.tag       = tagWord[TagWidth-1:0];
                req.name      = nameWord[NameWidth-1:0];
                sendOp(req, gap, expData);
            end
            rc = $fgets(line, fd);
        end
        $fclose(fd);

        @(posedge clk);
        issueWant <= 1'b0;
        waited = 0;
        while (doneCount != issuedCount) begin
            waited++;
            if (waited > WaitLimit) begin
                $display("timeout: %0d of %0d operations finished", doneCount, issuedCount);
                abortRun();
            end
            @(posedge clk);
        end

        // a few quiet cycles catch stray done pulses or writes
        repeat (10) @(posedge clk);
        checkDoneCount(doneCount, issuedCount);
        if (expected.size() != 0) begin
            $display("%0d loads never wrote the reorder buffer", expected.size());
            abortRun();
        end
        if (latencyChecks == 0) begin
            $display("no operation ran into an idle pipeline, latency was never measured");
            abortRun();
        end
        if (!sawFull) begin
            $display("the queue never filled during the burst");
            abortRun();
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- vlog.f
rtl/lsPkg.sv
rtl/lsQueue.sv
rtl/lsUnit.sv
rtl/dataMemory.sv
rtl/lsTop.sv
bench/lsTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module lsTb -f vlog.f -o lsSim

./obj_dir/lsSim > sim.log 2>&1 || true
cat sim.log

if grep -qx "TESTBENCH PASSED" sim.log; then
    exit 0
fi
exit 1

//--- bench/lsStimulus.txt
# op base offset storeData tag name gap expected (op: 0 lb 1 lh 2 lw 3 lbu 4 lhu 5 sb 6 sh 7 sw)
# op and gap are decimal, all other columns hex; expected is ignored for stores
7 00000100 00000000 12345678 1 05 3 00000000
2 00000100 00000000 00000000 2 06 0 12345678
7 000000f0 00000014 80f17fe2 3 07 2 00000000
0 00000100 00000004 00000000 4 08 0 ffffffe2
0 00000110 fffffff5 00000000 5 09 0 0000007f
0 00000100 00000006 00000000 6 0a 1 fffffff1
0 00000100 00000007 00000000 7 0b 0 ffffff80
3 00000104 00000000 00000000 8 0c 0 000000e2
3 00000104 00000001 00000000 9 0d 0 0000007f
3 00000104 00000002 00000000 a 0e 0 000000f1
3 00000104 00000003 00000000 b 0f 0 00000080
1 00000104 00000000 00000000 c 10 0 00007fe2
1 00000104 00000002 00000000 d 11 0 ffff80f1
4 00000104 00000000 00000000 e 12 0 00007fe2
4 00000108 fffffffe 00000000 f 13 0 000080f1
7 00000108 00000000 aabbccdd 0 14 2 00000000
5 00000108 00000001 deadbe11 1 15 0 00000000
6 00000108 00000002 12345566 2 16 0 00000000
2 00000108 00000000 00000000 3 17 0 556611dd
5 0000010c 00000003 000000a5 4 18 1 00000000
2 0000010c 00000000 00000000 5 19 0 a5000000
6 00000110 00000000 ffff1234 6 1a 0 00000000
2 00000110 00000000 00000000 7 1b 0 00001234
2 00000100 00000000 00000000 8 01 5 12345678
2 00000100 00000004 00000000 9 02 0 80f17fe2
2 00000100 00000008 00000000 a 03 0 556611dd
0 00000108 00000003 00000000 b 04 0 00000055
4 00000108 00000002 00000000 c 1c 0 00005566
1 00000108 00000000 00000000 d 1d 0 000011dd
3 0000010c 00000003 00000000 e 1e 0 000000a5
0 0000010c 00000003 00000000 f 1f 0 ffffffa5
2 00000110 00000000 00000000 0 00 0 00001234
7 00000114 00000000 cafef00d 1 01 0 00000000
2 00000114 00000000 00000000 2 02 0 cafef00d
2 00000114 00000000 00000000 3 03 40 cafef00d
